// File: verilog/ddr3_pkg.sv
package ddr3_pkg;

  // command codes, {ras_n, cas_n, we_n}
  localparam logic [2:0] cmd_mode = 3'd0;
  localparam logic [2:0] cmd_refr = 3'd1;
  localparam logic [2:0] cmd_prec = 3'd2;
  localparam logic [2:0] cmd_actv = 3'd3;
  localparam logic [2:0] cmd_writ = 3'd4;
  localparam logic [2:0] cmd_read = 3'd5;
  localparam logic [2:0] cmd_zqcl = 3'd6;
  localparam logic [2:0] cmd_noop = 3'd7;

  // 1Gb x16 part, low 3 column bits implied by the BL8 burst
  localparam int tid_bits   = 4;
  localparam int row_bits   = 13;
  localparam int col_bits   = 10;
  localparam int bank_bits  = 3;
  localparam int burst_bits = 3;
  localparam int addr_bits  = row_bits + bank_bits + col_bits - burst_bits;

  // ready held low after each accepted command, in clocks
  localparam int t_rcd       = 3;
  localparam int t_ccd       = 4;
  localparam int t_rp        = 3;
  localparam int t_rfc       = 8;
  localparam int t_mrd       = 4;
  localparam int t_zqinit    = 12;
  localparam int t_refi      = 150;
  localparam int t_init_wait = 20;

  // power-up table length, entries live in the sequencer
  localparam int init_len = 6;

  // counter widths
  localparam int busy_bits = 4;
  localparam int refi_bits = 8;
  localparam int wait_bits = 5;
  localparam int step_bits = 3;

  // scheduler states
  localparam logic [2:0] st_idle = 3'd0;
  localparam logic [2:0] st_actv = 3'd1;
  localparam logic [2:0] st_read = 3'd2;
  localparam logic [2:0] st_writ = 3'd3;
  localparam logic [2:0] st_refr = 3'd4;

  // column view, A10 is auto-precharge
  typedef struct packed {
    logic [row_bits-col_bits-2:0] pad;
    logic                         ap;
    logic [col_bits-1:0]          cadr;
  } ddr3_col_t;

  typedef union packed {
    logic [row_bits-1:0] row;
    ddr3_col_t           col;
  } ddr3_adr_u;

  typedef struct packed {
    logic [2:0]           cmd;
    logic [bank_bits-1:0] ba;
    ddr3_adr_u            adr;
    logic [tid_bits-1:0]  tid;
  } ddr3_cmd_t;

  typedef struct packed {
    logic                 req;
    logic                 lst;
    logic [tid_bits-1:0]  tid;
    logic [addr_bits-1:0] adr;
  } ddr3_req_t;

endpackage

// File: verilog/ddr3_init.sv
`timescale 1ns/100ps
module ddr3_init (
  input  logic                clock,
  input  logic                reset,
  input  logic                cfg_rdy_i,
  output logic                cfg_req_o,
  output logic [2:0]          cfg_cmd_o,
  output logic [2:0]          cfg_ba_o,
  output ddr3_pkg::ddr3_adr_u cfg_adr_o,
  output logic                init_done_o
);
  import ddr3_pkg::*;

  logic [wait_bits-1:0] wait_q;
  logic [step_bits-1:0] step_q;

  // request once the idle time is over, until the table is exhausted
  assign cfg_req_o   = (wait_q == '0) && (step_q != step_bits'(init_len));
  assign init_done_o = (step_q == step_bits'(init_len));

  always_ff @(posedge clock) begin
    if (reset) begin
      wait_q <= wait_bits'(t_init_wait);
      step_q <= '0;
    end else if (wait_q != '0) begin
      wait_q <= wait_q - 1'b1;
    end else if (cfg_req_o && cfg_rdy_i) begin
      step_q <= step_q + 1'b1;
    end
  end

  // init table, mode registers in MR2, MR3, MR1, MR0 order
  always_comb begin
    cfg_cmd_o     = cmd_noop;
    cfg_ba_o      = 3'd0;
    cfg_adr_o.row = '0;
    case (step_q)
      3'd0: begin
        // CWL 6
        cfg_cmd_o     = cmd_mode;
        cfg_ba_o      = 3'd2;
        cfg_adr_o.row = 13'h0008;
      end
      3'd1: begin
        cfg_cmd_o = cmd_mode;
        cfg_ba_o  = 3'd3;
      end
      3'd2: begin
        // DLL on, RTT_nom rzq/4
        cfg_cmd_o     = cmd_mode;
        cfg_ba_o      = 3'd1;
        cfg_adr_o.row = 13'h0004;
      end
      3'd3: begin
        // BL8, CL 6, WR 6, DLL reset
        cfg_cmd_o     = cmd_mode;
        cfg_ba_o      = 3'd0;
        cfg_adr_o.row = 13'h0520;
      end
      3'd4: begin
        // long calibration, A10 high
        cfg_cmd_o     = cmd_zqcl;
        cfg_adr_o.row = 13'h0400;
      end
      3'd5: begin
        // precharge all banks
        cfg_cmd_o     = cmd_prec;
        cfg_adr_o.row = 13'h0400;
      end
      default: begin
        cfg_cmd_o = cmd_noop;
      end
    endcase
  end

  // the step count never runs past the end of the table
  assert property (@(posedge clock) disable iff (reset) step_q <= step_bits'(init_len));

endmodule

// File: verilog/ddr3_fsm.sv
`timescale 1ns/100ps
module ddr3_fsm (
  input  logic                clock,
  input  logic                reset,
  input  ddr3_pkg::ddr3_req_t wr_i,
  input  ddr3_pkg::ddr3_req_t rd_i,
  output logic                wr_ack_o,
  output logic                wr_err_o,
  output logic                rd_ack_o,
  output logic                rd_err_o,
  input  logic                cfg_req_i,
  output logic                cfg_rdy_o,
  input  logic [2:0]          cfg_cmd_i,
  input  logic [2:0]          cfg_ba_i,
  input  ddr3_pkg::ddr3_adr_u cfg_adr_i,
  output logic                ddl_req_o,
  input  logic                ddl_rdy_i,
  input  logic                ddl_ref_i,
  output ddr3_pkg::ddr3_cmd_t ddl_cmd_o
);
  import ddr3_pkg::*;

  logic [2:0] state_q;
  // bus stage, queued column command, and more beats expected
  logic       req_q;
  logic       req_x;
  logic       req_s;
  ddr3_cmd_t  cmd_q;
  ddr3_cmd_t  cmd_x;
  // row and bank opened by the current sequence
  logic [row_bits-1:0]  row_q;
  logic [bank_bits-1:0] ba_q;
  logic                 sel_rd_q;
  logic                 wr_ack_q;
  logic                 wr_err_q;
  logic                 rd_ack_q;
  logic                 rd_err_q;

  logic                 pick_rd_w;
  ddr3_req_t            port_w;
  logic [row_bits-1:0]  row_w;
  logic [bank_bits-1:0] bank_w;
  logic [col_bits-1:0]  col_w;
  ddr3_cmd_t            col_cmd_w;
  ddr3_cmd_t            cfg_word_w;
  logic                 accept_w;
  logic                 load_w;
  logic                 beat_w;
  logic                 match_w;

  // reads win from idle, then the chosen port is kept for the sequence
  assign pick_rd_w = (state_q == st_idle) ? rd_i.req : sel_rd_q;
  assign port_w    = pick_rd_w ? rd_i : wr_i;

  // address split, {row, bank, col[9:3]}
  assign {row_w, bank_w} = port_w.adr[addr_bits-1 -: row_bits + bank_bits];
  assign col_w = {port_w.adr[col_bits-burst_bits-1:0], {burst_bits{1'b0}}};

  always_comb begin
    col_cmd_w              = '0;
    col_cmd_w.cmd          = pick_rd_w ? cmd_read : cmd_writ;
    col_cmd_w.ba           = bank_w;
    col_cmd_w.adr.col.cadr = col_w;
    // last beat closes the row
    col_cmd_w.adr.col.ap   = port_w.lst;
    col_cmd_w.tid          = port_w.tid;
  end

  assign accept_w = req_q & ddl_rdy_i;
  // queued command moves to the bus once the bus frees up
  assign load_w   = req_x & (accept_w | ~req_q);
  // skip a cycle after ack or error, the requester is still changing its port
  assign beat_w   = req_s & port_w.req & ~(wr_ack_q | rd_ack_q | wr_err_q | rd_err_q) &
                    (~req_x | load_w);
  assign match_w  = (row_w == row_q) && (bank_w == ba_q);

  // held in reset, the config port drives the bus directly
  assign cfg_word_w = {cfg_cmd_i, cfg_ba_i, cfg_adr_i, {tid_bits{1'b0}}};
  assign cfg_rdy_o  = ddl_rdy_i;
  assign ddl_req_o  = reset ? cfg_req_i : req_q;
  assign ddl_cmd_o  = reset ? cfg_word_w : cmd_q;

  assign wr_ack_o = wr_ack_q;
  assign wr_err_o = wr_err_q;
  assign rd_ack_o = rd_ack_q;
  assign rd_err_o = rd_err_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q  <= st_idle;
      req_q    <= 1'b0;
      req_x    <= 1'b0;
      req_s    <= 1'b0;
      sel_rd_q <= 1'b0;
      wr_ack_q <= 1'b0;
      wr_err_q <= 1'b0;
      rd_ack_q <= 1'b0;
      rd_err_q <= 1'b0;
    end else begin
      // strobes last one cycle
      wr_ack_q <= 1'b0;
      wr_err_q <= 1'b0;
      rd_ack_q <= 1'b0;
      rd_err_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (ddl_ref_i) begin
            state_q         <= st_refr;
            req_q           <= 1'b1;
            cmd_q.cmd       <= cmd_refr;
            cmd_q.ba        <= '0;
            cmd_q.adr.row   <= '0;
            cmd_q.tid       <= '0;
          end else if (rd_i.req || wr_i.req) begin
            // activate now, first column command queued behind it
            state_q       <= st_actv;
            sel_rd_q      <= rd_i.req;
            req_q         <= 1'b1;
            cmd_q.cmd     <= cmd_actv;
            cmd_q.ba      <= bank_w;
            cmd_q.adr.row <= row_w;
            cmd_q.tid     <= port_w.tid;
            row_q         <= row_w;
            ba_q          <= bank_w;
            cmd_x         <= col_cmd_w;
            req_x         <= 1'b1;
            req_s         <= ~port_w.lst;
            rd_ack_q      <= rd_i.req;
            wr_ack_q      <= ~rd_i.req;
          end
        end
        st_refr: begin
          if (accept_w) begin
            state_q <= st_idle;
            req_q   <= 1'b0;
          end
        end
        default: begin
          // activate, read or write on the bus
          if (load_w) begin
            state_q <= sel_rd_q ? st_read : st_writ;
            req_q   <= 1'b1;
            cmd_q   <= cmd_x;
          end else if (accept_w || !req_q) begin
            req_q <= 1'b0;
            // nothing queued and no beat to come, sequence is over
            if (!req_s) begin
              state_q <= st_idle;
            end
          end
          if (beat_w && match_w) begin
            cmd_x    <= col_cmd_w;
            req_s    <= ~port_w.lst;
            rd_ack_q <= sel_rd_q;
            wr_ack_q <= ~sel_rd_q;
          end else if (beat_w) begin
            // other row or bank, refuse the beat and end the sequence
            req_s    <= 1'b0;
            rd_err_q <= sel_rd_q;
            wr_err_q <= ~sel_rd_q;
          end
          req_x <= (beat_w & match_w) | (req_x & ~load_w);
        end
      endcase
    end
  end

  // a beat is either taken or refused, never both
  assert property (@(posedge clock) disable iff (reset)
    !(wr_ack_o && wr_err_o) && !(rd_ack_o && rd_err_o));
  // only one port is served per sequence
  assert property (@(posedge clock) disable iff (reset) !(wr_ack_o && rd_ack_o));
  // a presented command holds until the data layer takes it
  assert property (@(posedge clock) disable iff (reset)
    ddl_req_o && !ddl_rdy_i |=> ddl_req_o && $stable(ddl_cmd_o));

endmodule

// File: verilog/ddr3_ddl.sv
`timescale 1ns/100ps
module ddr3_ddl (
  input  logic                clock,
  input  logic                reset,
  input  logic                ddl_req_i,
  input  ddr3_pkg::ddr3_cmd_t ddl_cmd_i,
  output logic                ddl_rdy_o,
  output logic                ddl_ref_o,
  output ddr3_pkg::ddr3_cmd_t cmd_o,
  output logic                cmd_valid_o
);
  import ddr3_pkg::*;

  logic                 accept_w;
  logic [busy_bits-1:0] hold_w;
  logic [busy_bits-1:0] busy_q;
  logic                 rdy_q;
  logic [refi_bits-1:0] refi_q;
  logic                 ref_q;

  assign accept_w    = ddl_req_i & rdy_q;
  assign ddl_rdy_o   = rdy_q;
  assign ddl_ref_o   = ref_q;
  // the accepted command, valid only in its acceptance cycle
  assign cmd_o       = ddl_cmd_i;
  assign cmd_valid_o = accept_w;

  // busy time per command
  always_comb begin
    case (ddl_cmd_i.cmd)
      cmd_actv: hold_w = busy_bits'(t_rcd);
      cmd_read: hold_w = busy_bits'(t_ccd);
      cmd_writ: hold_w = busy_bits'(t_ccd);
      cmd_prec: hold_w = busy_bits'(t_rp);
      cmd_refr: hold_w = busy_bits'(t_rfc);
      cmd_mode: hold_w = busy_bits'(t_mrd);
      cmd_zqcl: hold_w = busy_bits'(t_zqinit);
      default:  hold_w = '0;
    endcase
  end

  // ready drops after acceptance and comes back as the count runs out
  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q <= '0;
      rdy_q  <= 1'b1;
    end else if (accept_w) begin
      busy_q <= hold_w;
      rdy_q  <= (hold_w == '0);
    end else if (busy_q != '0) begin
      busy_q <= busy_q - 1'b1;
      rdy_q  <= (busy_q == busy_bits'(1));
    end
  end

  // refresh interval, free running
  always_ff @(posedge clock) begin
    if (reset) begin
      refi_q <= refi_bits'(t_refi - 1);
      ref_q  <= 1'b0;
    end else begin
      if (refi_q == '0) begin
        refi_q <= refi_bits'(t_refi - 1);
      end else begin
        refi_q <= refi_q - 1'b1;
      end
      // expiry wins over a refresh taken in the same cycle
      if (refi_q == '0) begin
        ref_q <= 1'b1;
      end else if (accept_w && ddl_cmd_i.cmd == cmd_refr) begin
        ref_q <= 1'b0;
      end
    end
  end

  assert property (@(posedge clock) disable iff (reset) rdy_q |-> busy_q == '0);

endmodule

// File: verilog/ddr3_ctrl.sv
`timescale 1ns/100ps
module ddr3_ctrl (
  input  logic                clock,
  input  logic                reset,
  input  ddr3_pkg::ddr3_req_t wr_i,
  input  ddr3_pkg::ddr3_req_t rd_i,
  output logic                wr_ack_o,
  output logic                wr_err_o,
  output logic                rd_ack_o,
  output logic                rd_err_o,
  output ddr3_pkg::ddr3_cmd_t cmd_o,
  output logic                cmd_valid_o,
  output logic                init_done_o
);
  import ddr3_pkg::*;

  logic       fsm_reset_w;
  logic       cfg_req_w;
  logic       cfg_rdy_w;
  logic [2:0] cfg_cmd_w;
  logic [2:0] cfg_ba_w;
  ddr3_adr_u  cfg_adr_w;
  logic       ddl_req_w;
  logic       ddl_rdy_w;
  logic       ddl_ref_w;
  ddr3_cmd_t  ddl_cmd_w;

  // scheduler stays in config pass-through until power-up is done
  assign fsm_reset_w = reset | ~init_done_o;

  ddr3_init ddr3_init_i (
    .clock       (clock),
    .reset       (reset),
    .cfg_rdy_i   (cfg_rdy_w),
    .cfg_req_o   (cfg_req_w),
    .cfg_cmd_o   (cfg_cmd_w),
    .cfg_ba_o    (cfg_ba_w),
    .cfg_adr_o   (cfg_adr_w),
    .init_done_o (init_done_o)
  );

  ddr3_fsm ddr3_fsm_i (
    .clock     (clock),
    .reset     (fsm_reset_w),
    .wr_i      (wr_i),
    .rd_i      (rd_i),
    .wr_ack_o  (wr_ack_o),
    .wr_err_o  (wr_err_o),
    .rd_ack_o  (rd_ack_o),
    .rd_err_o  (rd_err_o),
    .cfg_req_i (cfg_req_w),
    .cfg_rdy_o (cfg_rdy_w),
    .cfg_cmd_i (cfg_cmd_w),
    .cfg_ba_i  (cfg_ba_w),
    .cfg_adr_i (cfg_adr_w),
    .ddl_req_o (ddl_req_w),
    .ddl_rdy_i (ddl_rdy_w),
    .ddl_ref_i (ddl_ref_w),
    .ddl_cmd_o (ddl_cmd_w)
  );

  ddr3_ddl ddr3_ddl_i (
    .clock       (clock),
    .reset       (reset),
    .ddl_req_i   (ddl_req_w),
    .ddl_cmd_i   (ddl_cmd_w),
    .ddl_rdy_o   (ddl_rdy_w),
    .ddl_ref_o   (ddl_ref_w),
    .cmd_o       (cmd_o),
    .cmd_valid_o (cmd_valid_o)
  );

endmodule

// File: test/ddr3_ctrl_tb.sv
`timescale 1ns/100ps
module ddr3_ctrl_tb;
  import ddr3_pkg::*;

  logic      clock;
  logic      reset;
  ddr3_req_t wr_i;
  ddr3_req_t rd_i;
  logic      wr_ack_o;
  logic      wr_err_o;
  logic      rd_ack_o;
  logic      rd_err_o;
  ddr3_cmd_t cmd_o;
  logic      cmd_valid_o;
  logic      init_done_o;

  integer seed;
  // expected command queue, refresh is checked on its own
  ddr3_cmd_t exp_mem [0:63];
  ddr3_cmd_t msk_mem [0:63];
  logic [5:0] exp_wr;
  logic [5:0] exp_rd;
  // strobe counters and their expected values
  int rd_ack_cnt;
  int wr_ack_cnt;
  int rd_err_cnt;
  int wr_err_cnt;
  int rd_ack_exp;
  int wr_ack_exp;
  int rd_err_exp;
  int wr_err_exp;
  // cycles since the last command and since the last refresh
  int   gap_q;
  int   hold_q;
  int   ref_gap_q;
  logic ref_watch;
  // scheduler bus seen one cycle back
  logic      req_d_q;
  logic      ref_d_q;
  logic      fsm_req_w;
  logic      fsm_ref_w;
  ddr3_cmd_t fsm_cmd_w;

  ddr3_ctrl ddr3_ctrl_i (
    .clock       (clock),
    .reset       (reset),
    .wr_i        (wr_i),
    .rd_i        (rd_i),
    .wr_ack_o    (wr_ack_o),
    .wr_err_o    (wr_err_o),
    .rd_ack_o    (rd_ack_o),
    .rd_err_o    (rd_err_o),
    .cmd_o       (cmd_o),
    .cmd_valid_o (cmd_valid_o),
    .init_done_o (init_done_o)
  );

  assign fsm_req_w = ddr3_ctrl_i.ddl_req_w;
  assign fsm_ref_w = ddr3_ctrl_i.ddl_ref_w;
  assign fsm_cmd_w = ddr3_ctrl_i.ddl_cmd_w;

  always #20 clock = ~clock;

  task automatic end_with_errors();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    end_with_errors();
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timed out at %0t while waiting for %s", $time, what);
    end_with_errors();
  endtask

  // ready stays low this long after each command
  function automatic int hold_cycles(input logic [2:0] c);
    case (c)
      cmd_actv: return t_rcd;
      cmd_read: return t_ccd;
      cmd_writ: return t_ccd;
      cmd_prec: return t_rp;
      cmd_refr: return t_rfc;
      cmd_mode: return t_mrd;
      cmd_zqcl: return t_zqinit;
      default:  return 0;
    endcase
  endfunction

  function automatic ddr3_req_t random_beat(input logic [tid_bits-1:0] tid);
    ddr3_req_t b;
    b.req = 1'b1;
    b.lst = 1'b1;
    b.tid = tid;
    b.adr = addr_bits'($random(seed));
    return b;
  endfunction

  task automatic push_expect(input ddr3_cmd_t c, input ddr3_cmd_t m);
    exp_mem[exp_wr] = c;
    msk_mem[exp_wr] = m;
    exp_wr = exp_wr + 1'b1;
  endtask

  // MODE on banks 2, 3, 1, 0, then ZQCL, then PRECHARGE with A10
  task automatic load_init_table();
    ddr3_cmd_t c;
    ddr3_cmd_t m;
    c = '0;
    m = '0;
    m.cmd = '1;
    m.ba = '1;
    m.tid = '1;
    c.cmd = cmd_mode;
    c.ba = 3'd2;
    push_expect(c, m);
    c.ba = 3'd3;
    push_expect(c, m);
    c.ba = 3'd1;
    push_expect(c, m);
    c.ba = 3'd0;
    push_expect(c, m);
    // mode register contents are not checked
    m.ba = '0;
    c.cmd = cmd_zqcl;
    push_expect(c, m);
    c.cmd = cmd_prec;
    c.adr.row[10] = 1'b1;
    m.adr.row[10] = 1'b1;
    push_expect(c, m);
  endtask

  // address is {row, bank, col[9:3]}
  task automatic push_beat(input logic is_rd, input ddr3_req_t r, input logic first);
    ddr3_cmd_t c;
    if (first) begin
      c = '0;
      c.cmd = cmd_actv;
      c.ba = r.adr[addr_bits-row_bits-1 -: bank_bits];
      c.adr.row = r.adr[addr_bits-1 -: row_bits];
      c.tid = r.tid;
      push_expect(c, '1);
    end
    c = '0;
    c.cmd = is_rd ? cmd_read : cmd_writ;
    c.ba = r.adr[addr_bits-row_bits-1 -: bank_bits];
    c.adr.col.ap = r.lst;
    c.adr.col.cadr = {r.adr[col_bits-burst_bits-1:0], 3'b000};
    c.tid = r.tid;
    push_expect(c, '1);
  endtask

  task automatic wait_strobe(input logic is_rd, output logic got_err);
    int n;
    logic seen;
    n = 0;
    seen = 1'b0;
    got_err = 1'b0;
    while (!seen) begin
      @(negedge clock);
      if (is_rd ? (rd_ack_o || rd_err_o) : (wr_ack_o || wr_err_o)) begin
        seen = 1'b1;
        got_err = is_rd ? rd_err_o : wr_err_o;
      end else begin
        n++;
        if (n > 100) stop_on_timeout("an ack or error on a request port");
      end
    end
  endtask

  // one burst on a port, bad_beat points at a beat to another row
  task automatic run_burst(input logic is_rd, input int beats, input int bad_beat,
                           input logic [tid_bits-1:0] tid0);
    ddr3_req_t base;
    ddr3_req_t b;
    logic got_err;
    int i;
    base = random_beat(tid0);
    got_err = 1'b0;
    i = 0;
    while (i < beats && !got_err) begin
      b = base;
      b.lst = (i == beats - 1);
      b.tid = tid0 + i[tid_bits-1:0];
      b.adr[col_bits-burst_bits-1:0] = base.adr[col_bits-burst_bits-1:0] +
                                       i[col_bits-burst_bits-1:0];
      if (i == bad_beat) begin
        b.adr[addr_bits-1 -: row_bits] = base.adr[addr_bits-1 -: row_bits] + 1'b1;
      end else begin
        push_beat(is_rd, b, i == 0);
      end
      if (is_rd) rd_i = b;
      else wr_i = b;
      wait_strobe(is_rd, got_err);
      assert (got_err == (i == bad_beat))
        else report_fail("error strobe where an ack was due, or the reverse");
      i++;
    end
    rd_i.req = 1'b0;
    wr_i.req = 1'b0;
    if (is_rd) begin
      rd_ack_exp += (bad_beat >= 0) ? bad_beat : beats;
      rd_err_exp += (bad_beat >= 0) ? 1 : 0;
    end else begin
      wr_ack_exp += (bad_beat >= 0) ? bad_beat : beats;
      wr_err_exp += (bad_beat >= 0) ? 1 : 0;
    end
  endtask

  // all expected commands seen, then the strobe counts must agree
  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_rd != exp_wr) begin
      @(negedge clock);
      n++;
      if (n > 300) stop_on_timeout("the expected commands to appear");
    end
    assert (rd_ack_cnt == rd_ack_exp && wr_ack_cnt == wr_ack_exp)
      else report_fail("number of acks differs from the number of beats");
    assert (rd_err_cnt == rd_err_exp && wr_err_cnt == wr_err_exp)
      else report_fail("number of error pulses is wrong");
  endtask

  task automatic wait_refresh(input int limit);
    int n;
    n = 0;
    while (!(cmd_valid_o && cmd_o.cmd == cmd_refr)) begin
      @(negedge clock);
      n++;
      if (n > limit) stop_on_timeout("a REFRESH command");
    end
    @(negedge clock);
  endtask

  task automatic wait_refresh_due();
    int n;
    n = 0;
    while (!fsm_ref_w) begin
      @(negedge clock);
      n++;
      if (n > t_refi + 20) stop_on_timeout("a refresh request");
    end
  endtask

  always @(posedge clock) begin
    if (reset) begin
      exp_rd <= '0;
      rd_ack_cnt <= 0;
      wr_ack_cnt <= 0;
      rd_err_cnt <= 0;
      wr_err_cnt <= 0;
      gap_q <= 1000;
      hold_q <= 0;
      ref_gap_q <= 0;
      req_d_q <= 1'b0;
      ref_d_q <= 1'b0;
    end else begin
      if (cmd_valid_o && cmd_o.cmd != cmd_refr) exp_rd <= exp_rd + 1'b1;
      if (rd_ack_o) rd_ack_cnt <= rd_ack_cnt + 1;
      if (wr_ack_o) wr_ack_cnt <= wr_ack_cnt + 1;
      if (rd_err_o) rd_err_cnt <= rd_err_cnt + 1;
      if (wr_err_o) wr_err_cnt <= wr_err_cnt + 1;
      if (cmd_valid_o) begin
        gap_q <= 1;
        hold_q <= hold_cycles(cmd_o.cmd);
      end else begin
        gap_q <= gap_q + 1;
      end
      if (cmd_valid_o && cmd_o.cmd == cmd_refr) ref_gap_q <= 1;
      else ref_gap_q <= ref_gap_q + 1;
      req_d_q <= fsm_req_w;
      ref_d_q <= fsm_ref_w;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    cmd_valid_o && cmd_o.cmd != cmd_refr |-> exp_rd != exp_wr)
    else report_fail("command issued with none expected");
  assert property (@(posedge clock) disable iff (reset)
    cmd_valid_o && cmd_o.cmd != cmd_refr && exp_rd != exp_wr |->
    ((cmd_o ^ exp_mem[exp_rd]) & msk_mem[exp_rd]) == '0)
    else report_fail("command differs from the expected one");
  assert property (@(posedge clock) disable iff (reset) cmd_valid_o |-> gap_q > hold_q)
    else report_fail("commands closer than the previous command allows");
  assert property (@(posedge clock) disable iff (reset)
    !init_done_o |-> !(rd_ack_o || wr_ack_o || rd_err_o || wr_err_o))
    else report_fail("request port strobe before init done");
  // power-up table fully issued by the time init_done_o rises
  assert property (@(posedge clock) disable iff (reset)
    $rose(init_done_o) |-> exp_rd == 6'(init_len))
    else report_fail("init_done_o before the init table ran");
  // an ACTIVATE is never chosen while a refresh is pending
  assert property (@(posedge clock) disable iff (reset)
    fsm_req_w && !req_d_q && fsm_cmd_w.cmd == cmd_actv |-> !ref_d_q)
    else report_fail("ACTIVATE issued with a refresh pending");
  assert property (@(posedge clock) disable iff (reset)
    ref_watch && cmd_valid_o && cmd_o.cmd == cmd_refr |-> ref_gap_q <= t_refi + t_rfc)
    else report_fail("REFRESH interval too long");

  initial begin
    ddr3_req_t rb;
    ddr3_req_t wb;
    logic got_err;
    clock = 1'b0;
    reset = 1'b1;
    wr_i = '0;
    rd_i = '0;
    seed = 32'h532bb906;
    exp_wr = '0;
    rd_ack_exp = 0;
    wr_ack_exp = 0;
    rd_err_exp = 0;
    wr_err_exp = 0;
    ref_watch = 1'b0;
    load_init_table();
    repeat (4) @(negedge clock);
    reset = 1'b0;

    // single read held on its port through power-up, served once init is done
    run_burst(1'b1, 1, -1, 4'h1);
    wait_drain();
    // write burst of 2 to 4 beats
    run_burst(1'b0, 2 + int'($unsigned($random(seed)) % 3), -1, 4'h4);
    wait_drain();

    // both ports at once, the read goes first
    rb = random_beat(4'h9);
    wb = random_beat(4'hc);
    push_beat(1'b1, rb, 1'b1);
    push_beat(1'b0, wb, 1'b1);
    rd_i = rb;
    wr_i = wb;
    wait_strobe(1'b1, got_err);
    rd_i.req = 1'b0;
    wait_strobe(1'b0, got_err);
    wr_i.req = 1'b0;
    rd_ack_exp += 1;
    wr_ack_exp += 1;
    wait_drain();

    // second beat to another row is refused
    run_burst(1'b1, 3, 1, 4'h6);
    wait_drain();

    // idle ports, refresh at the interval
    wait_refresh(2 * t_refi);
    ref_watch = 1'b1;
    wait_refresh(t_refi + t_rfc + 20);
    wait_refresh(t_refi + t_rfc + 20);

    // request arrives with a refresh pending
    wait_refresh_due();
    run_burst(1'b1, 1, -1, 4'h2);
    wait_drain();

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: ddr3_ctrl.f
verilog/ddr3_pkg.sv
verilog/ddr3_init.sv
verilog/ddr3_fsm.sv
verilog/ddr3_ddl.sv
verilog/ddr3_ctrl.sv
test/ddr3_ctrl_tb.sv

// File: Makefile
TOP = ddr3_ctrl_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f ddr3_ctrl.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Finished with no errors" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
